// ==== rtl/board_ctrl_defines.svh ====
`ifndef BOARD_CTRL_DEFINES_SVH
`define BOARD_CTRL_DEFINES_SVH

// vector and frame widths
`define GPIO_WIDTH         64
`define SPI_FRAME_BITS     24
`define SPI_CS_NUM         8
// sys_clk cycles per spi clock half period
`define SPI_CLK_DIV        2

// host bus
`define HOST_ADDR_BITS     4
`define HOST_DATA_BITS     32
`define SPI_CTRL_START_BIT 8

// register map
`define REG_GPIO_OUT_LO    4'd0
`define REG_GPIO_OUT_HI    4'd1
`define REG_GPIO_IN_LO     4'd2
`define REG_GPIO_IN_HI     4'd3
`define REG_SPI_CTRL       4'd4
`define REG_SPI_TXDATA     4'd5
`define REG_SPI_STATUS     4'd6
`define REG_SPI_RXDATA     4'd7

// gpio bit map, converter and clock chip controls
`define GPIO_BIT_FIFO_BYPASS  60
`define GPIO_BIT_AD9528_RESET 59
`define GPIO_BIT_SYSREF_REQ   58
`define GPIO_BIT_TX1_ENABLE   57
`define GPIO_BIT_TX2_ENABLE   56
`define GPIO_BIT_RX1_ENABLE   55
`define GPIO_BIT_RX2_ENABLE   54
`define GPIO_BIT_TEST         53
`define GPIO_BIT_AD9371_RESET 52
`define GPIO_BIT_GPINT        51
// board switches in, leds out
`define GPIO_BD_IN_MSB        26
`define GPIO_BD_IN_LSB        16
`define GPIO_LED_MSB          15
`define GPIO_LED_LSB          0

`endif

// ==== rtl/board_ctrl_pkg.sv ====
`include "board_ctrl_defines.svh"

// ********************************************************************
// shared types for the board control block
// ********************************************************************

package board_ctrl_pkg;

  // full gpio vector, output and input side alike
  typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

  // one spi transaction, msb first on the wire
  typedef logic [`SPI_FRAME_BITS-1:0] spi_word_t;

  // chip select index
  typedef logic [$clog2(`SPI_CS_NUM)-1:0] spi_cs_t;

  // host register address
  typedef logic [`HOST_ADDR_BITS-1:0] reg_addr_t;

endpackage

// ==== rtl/ctrl_regs.sv ====
`timescale 1ns/1ps

`include "board_ctrl_defines.svh"

module ctrl_regs
  import board_ctrl_pkg::*;
(
  input  logic                       sys_clk_i,
  input  logic                       arst_n_i,

  // host bus
  input  logic                       host_wr_i,
  input  logic                       host_rd_i,
  input  logic [`HOST_ADDR_BITS-1:0] host_addr_i,
  input  logic [`HOST_DATA_BITS-1:0] host_wdata_i,
  output logic [`HOST_DATA_BITS-1:0] host_rdata_o,
  output logic                       host_rvalid_o,

  // gpio vectors
  input  gpio_vec_t                  gpio_in_i,
  output gpio_vec_t                  gpio_out_o,

  // spi engine
  input  logic                       spi_busy_i,
  input  logic                       spi_done_i,
  input  spi_word_t                  spi_rx_word_i,
  output logic                       spi_start_o,
  output spi_cs_t                    spi_cs_sel_o,
  output spi_word_t                  spi_tx_word_o
);

  localparam int unsigned DW = `HOST_DATA_BITS;

  reg_addr_t                 addr;
  logic                      wr_gpio_lo;
  logic                      wr_gpio_hi;
  logic                      wr_ctrl;
  logic                      wr_txdata;
  logic                      start_req;
  logic                      start_accept;
  logic                      busy_status;

  gpio_vec_t                 gpio_out_q;
  gpio_vec_t                 gpio_meta_q;
  gpio_vec_t                 gpio_sync_q;
  spi_word_t                 tx_word_q;
  spi_word_t                 rx_word_q;
  spi_cs_t                   cs_sel_q;
  logic                      start_q;
  logic                      done_q;
  logic                      rvalid_q;
  logic [DW-1:0]             rd_mux;
  logic [DW-1:0]             rdata_q;

  // ********************************************************************
  // write decode
  // ********************************************************************

  assign addr       = reg_addr_t'(host_addr_i);
  assign wr_gpio_lo = host_wr_i && (addr == `REG_GPIO_OUT_LO);
  assign wr_gpio_hi = host_wr_i && (addr == `REG_GPIO_OUT_HI);
  assign wr_ctrl    = host_wr_i && (addr == `REG_SPI_CTRL);
  assign wr_txdata  = host_wr_i && (addr == `REG_SPI_TXDATA);

  // a start already in flight counts as busy
  assign start_req    = wr_ctrl && host_wdata_i[`SPI_CTRL_START_BIT];
  assign start_accept = start_req && !spi_busy_i && !start_q;
  assign busy_status  = spi_busy_i || start_q;

  // output vector, 32 bits per host word
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
    end else begin
      if (wr_gpio_lo) begin
        gpio_out_q[DW-1:0] <= host_wdata_i;
      end
      if (wr_gpio_hi) begin
        gpio_out_q[`GPIO_WIDTH-1:DW] <= host_wdata_i;
      end
    end
  end

  // spi control and status
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_word_q <= '0;
      rx_word_q <= '0;
      cs_sel_q  <= '0;
      start_q   <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      start_q <= start_accept;
      if (wr_txdata) begin
        tx_word_q <= host_wdata_i[`SPI_FRAME_BITS-1:0];
      end
      if (start_accept) begin
        cs_sel_q <= host_wdata_i[$bits(spi_cs_t)-1:0];
        done_q   <= 1'b0;
      end
      // sticky until the next accepted start
      if (spi_done_i) begin
        done_q    <= 1'b1;
        rx_word_q <= spi_rx_word_i;
      end
    end
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= host_rd_i;
    end
  end

  // ********************************************************************
  // input synchronizer and read path
  // ********************************************************************

  always_ff @(posedge sys_clk_i) begin
    gpio_meta_q <= gpio_in_i;
    gpio_sync_q <= gpio_meta_q;
  end

  always_comb begin
    rd_mux = '0;
    case (addr)
      `REG_GPIO_OUT_LO: rd_mux = gpio_out_q[DW-1:0];
      `REG_GPIO_OUT_HI: rd_mux = gpio_out_q[`GPIO_WIDTH-1:DW];
      `REG_GPIO_IN_LO:  rd_mux = gpio_sync_q[DW-1:0];
      `REG_GPIO_IN_HI:  rd_mux = gpio_sync_q[`GPIO_WIDTH-1:DW];
      `REG_SPI_CTRL:    rd_mux[$bits(spi_cs_t)-1:0] = cs_sel_q;
      `REG_SPI_TXDATA:  rd_mux[`SPI_FRAME_BITS-1:0] = tx_word_q;
      `REG_SPI_STATUS: begin
        rd_mux[0] = busy_status;
        rd_mux[1] = done_q;
      end
      `REG_SPI_RXDATA:  rd_mux[`SPI_FRAME_BITS-1:0] = rx_word_q;
      default:          rd_mux = '0;
    endcase
  end

  // read data held until the next read
  always_ff @(posedge sys_clk_i) begin
    if (host_rd_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign host_rdata_o  = rdata_q;
  assign host_rvalid_o = rvalid_q;
  assign gpio_out_o    = gpio_out_q;
  assign spi_start_o   = start_q;
  assign spi_cs_sel_o  = cs_sel_q;
  assign spi_tx_word_o = tx_word_q;

  // ********************************************************************
  // checks
  // ********************************************************************

  a_rvalid_after_rd : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    host_rd_i |=> host_rvalid_o)
    else $error("read strobe not answered on the next cycle");

  a_rvalid_only_after_rd : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    host_rvalid_o |-> $past(host_rd_i))
    else $error("read valid without a read strobe");

  // engine must be idle whenever a start reaches it
  a_start_when_idle : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    spi_start_o |-> !spi_busy_i)
    else $error("spi start issued while engine busy");

endmodule

// ==== rtl/spi_master.sv ====
`timescale 1ns/1ps

`include "board_ctrl_defines.svh"

module spi_master
  import board_ctrl_pkg::*;
(
  input  logic                   sys_clk_i,
  input  logic                   arst_n_i,

  // control from the register file
  input  logic                   start_i,
  input  spi_cs_t                cs_sel_i,
  input  spi_word_t              tx_word_i,
  output logic                   busy_o,
  output logic                   done_o,
  output spi_word_t              rx_word_o,

  // spi pins
  output logic [`SPI_CS_NUM-1:0] spi_csn_o,
  output logic                   spi_clk_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i
);

  localparam int unsigned CLK_DIV   = `SPI_CLK_DIV;
  localparam int unsigned MSB       = `SPI_FRAME_BITS - 1;
  localparam int unsigned HALF_LAST = 2 * `SPI_FRAME_BITS;
  localparam int unsigned DIV_W     = $clog2(CLK_DIV + 1);
  localparam int unsigned HALF_W    = $clog2(HALF_LAST + 2);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_GUARD
  } state_t;

  state_t                  state_q;
  logic [DIV_W-1:0]        div_q;
  logic [HALF_W-1:0]       half_q;
  logic [`SPI_CS_NUM-1:0]  csn_q;
  logic                    sclk_q;
  logic                    mosi_q;
  logic                    done_q;
  spi_word_t               tx_shift_q;
  spi_word_t               rx_shift_q;

  logic                    half_tick;
  logic                    last_tick;
  logic                    rise_tick;
  logic                    fall_tick;
  logic                    guard_end;

  // half period pacing
  assign half_tick = (state_q == ST_SHIFT) && (div_q == DIV_W'(CLK_DIV - 1));
  assign last_tick = half_tick && (half_q == HALF_W'(HALF_LAST));
  assign rise_tick = half_tick && !last_tick && !half_q[0];
  assign fall_tick = half_tick && half_q[0];
  // cs stays high a half period plus one cycle before the next frame
  assign guard_end = (state_q == ST_GUARD) && (div_q == DIV_W'(CLK_DIV));

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      div_q   <= '0;
      half_q  <= '0;
      csn_q   <= '1;
      sclk_q  <= 1'b0;
      mosi_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_SHIFT;
            div_q   <= '0;
            half_q  <= '0;
            csn_q   <= ~(`SPI_CS_NUM'(1) << cs_sel_i);
            mosi_q  <= tx_word_i[MSB];
          end
        end
        ST_SHIFT: begin
          if (half_tick) begin
            div_q  <= '0;
            half_q <= half_q + 1'b1;
          end else begin
            div_q <= div_q + 1'b1;
          end
          if (last_tick) begin
            state_q <= ST_GUARD;
            csn_q   <= '1;
            done_q  <= 1'b1;
          end
          if (rise_tick) begin
            sclk_q <= 1'b1;
          end
          // mode 0, next bit goes out on the falling edge
          if (fall_tick) begin
            sclk_q <= 1'b0;
            mosi_q <= tx_shift_q[MSB-1];
          end
        end
        ST_GUARD: begin
          if (guard_end) begin
            state_q <= ST_IDLE;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // shift registers, zeros fill in behind the transmit data
  always_ff @(posedge sys_clk_i) begin
    if ((state_q == ST_IDLE) && start_i) begin
      tx_shift_q <= tx_word_i;
    end else if (fall_tick) begin
      tx_shift_q <= {tx_shift_q[MSB-1:0], 1'b0};
    end
    if (rise_tick) begin
      rx_shift_q <= {rx_shift_q[MSB-1:0], spi_miso_i};
    end
  end

  assign busy_o     = (state_q != ST_IDLE);
  assign done_o     = done_q;
  assign rx_word_o  = rx_shift_q;
  assign spi_csn_o  = csn_q;
  assign spi_clk_o  = sclk_q;
  assign spi_mosi_o = mosi_q;

  a_one_csn_low : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    $onehot0(~spi_csn_o))
    else $error("more than one chip select active");

  // no clock toggles reach the bus outside a frame
  a_clk_idle_low : assert property (
    @(posedge sys_clk_i) disable iff (!arst_n_i)
    (&spi_csn_o) |-> !spi_clk_o)
    else $error("spi clock high with no chip selected");

endmodule

// ==== rtl/board_top.sv ====
`timescale 1ns/1ps

`include "board_ctrl_defines.svh"

module board_top
  import board_ctrl_pkg::*;
(
  input  logic                       sys_clk_i,
  input  logic                       arst_n_i,

  // host bus
  input  logic                       host_wr_i,
  input  logic                       host_rd_i,
  input  logic [`HOST_ADDR_BITS-1:0] host_addr_i,
  input  logic [`HOST_DATA_BITS-1:0] host_wdata_i,
  output logic [`HOST_DATA_BITS-1:0] host_rdata_o,
  output logic                       host_rvalid_o,

  // board gpio
  input  logic [10:0]                gpio_bd_i,
  output logic [15:0]                gpio_bd_o,

  // converter and clock chip control
  output logic                       ad9528_reset_b_o,
  output logic                       ad9528_sysref_req_o,
  output logic                       ad9371_tx1_enable_o,
  output logic                       ad9371_tx2_enable_o,
  output logic                       ad9371_rx1_enable_o,
  output logic                       ad9371_rx2_enable_o,
  output logic                       ad9371_test_o,
  output logic                       ad9371_reset_b_o,
  input  logic                       ad9371_gpint_i,
  output logic                       tx_fifo_bypass_o,

  // spi
  output logic                       spi_csn_ad9528_o,
  output logic                       spi_csn_ad9371_o,
  output logic                       spi_clk_o,
  output logic                       spi_mosi_o,
  input  logic                       spi_miso_i
);

  gpio_vec_t               gpio_out;
  gpio_vec_t               gpio_in;
  logic [`SPI_CS_NUM-1:0]  spi_csn;
  logic                    spi_start;
  logic                    spi_busy;
  logic                    spi_done;
  spi_cs_t                 spi_cs_sel;
  spi_word_t               spi_tx_word;
  spi_word_t               spi_rx_word;

  // ********************************************************************
  // gpio pin map
  // ********************************************************************

  assign tx_fifo_bypass_o    = gpio_out[`GPIO_BIT_FIFO_BYPASS];
  assign ad9528_reset_b_o    = gpio_out[`GPIO_BIT_AD9528_RESET];
  assign ad9528_sysref_req_o = gpio_out[`GPIO_BIT_SYSREF_REQ];
  assign ad9371_tx1_enable_o = gpio_out[`GPIO_BIT_TX1_ENABLE];
  assign ad9371_tx2_enable_o = gpio_out[`GPIO_BIT_TX2_ENABLE];
  assign ad9371_rx1_enable_o = gpio_out[`GPIO_BIT_RX1_ENABLE];
  assign ad9371_rx2_enable_o = gpio_out[`GPIO_BIT_RX2_ENABLE];
  assign ad9371_test_o       = gpio_out[`GPIO_BIT_TEST];
  assign ad9371_reset_b_o    = gpio_out[`GPIO_BIT_AD9371_RESET];
  assign gpio_bd_o           = gpio_out[`GPIO_LED_MSB:`GPIO_LED_LSB];

  // input side, loopback except the interrupt and switches
  assign gpio_in[`GPIO_WIDTH-1:`GPIO_BIT_GPINT+1] =
    gpio_out[`GPIO_WIDTH-1:`GPIO_BIT_GPINT+1];
  assign gpio_in[`GPIO_BIT_GPINT] = ad9371_gpint_i;
  assign gpio_in[`GPIO_BIT_GPINT-1:`GPIO_BD_IN_MSB+1] =
    gpio_out[`GPIO_BIT_GPINT-1:`GPIO_BD_IN_MSB+1];
  assign gpio_in[`GPIO_BD_IN_MSB:`GPIO_BD_IN_LSB] = gpio_bd_i;
  assign gpio_in[`GPIO_BD_IN_LSB-1:0] = gpio_out[`GPIO_BD_IN_LSB-1:0];

  // cs 0 is the clock chip, cs 1 the converter
  assign spi_csn_ad9528_o = spi_csn[0];
  assign spi_csn_ad9371_o = spi_csn[1];

  ctrl_regs u_ctrl_regs (
    .sys_clk_i     (sys_clk_i),
    .arst_n_i      (arst_n_i),
    .host_wr_i     (host_wr_i),
    .host_rd_i     (host_rd_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o),
    .host_rvalid_o (host_rvalid_o),
    .gpio_in_i     (gpio_in),
    .gpio_out_o    (gpio_out),
    .spi_busy_i    (spi_busy),
    .spi_done_i    (spi_done),
    .spi_rx_word_i (spi_rx_word),
    .spi_start_o   (spi_start),
    .spi_cs_sel_o  (spi_cs_sel),
    .spi_tx_word_o (spi_tx_word)
  );

  spi_master u_spi_master (
    .sys_clk_i  (sys_clk_i),
    .arst_n_i   (arst_n_i),
    .start_i    (spi_start),
    .cs_sel_i   (spi_cs_sel),
    .tx_word_i  (spi_tx_word),
    .busy_o     (spi_busy),
    .done_o     (spi_done),
    .rx_word_o  (spi_rx_word),
    .spi_csn_o  (spi_csn),
    .spi_clk_o  (spi_clk_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i)
  );

endmodule

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the active edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// ==== bench/tb_board_top.sv ====
`timescale 1ns/1ps

`include "board_ctrl_defines.svh"

module tb_board_top;

  localparam int unsigned CYCLES_PER_OP = 50 * `SPI_CLK_DIV + 20;

  typedef enum logic [2:0] {
    K_WR,
    K_RD,
    K_PIN,
    K_INP,
    K_SPI,
    K_SPI_BUSY
  } op_kind_t;

  typedef struct packed {
    op_kind_t    kind;
    logic [3:0]  addr;
    logic [63:0] data;
    logic [63:0] expected;
  } op_t;

  logic                       clk;
  logic                       arst_n;
  logic                       host_wr;
  logic                       host_rd;
  logic [`HOST_ADDR_BITS-1:0] host_addr;
  logic [`HOST_DATA_BITS-1:0] host_wdata;
  logic [`HOST_DATA_BITS-1:0] host_rdata;
  logic                       host_rvalid;
  logic [10:0]                gpio_bd_in;
  logic [15:0]                gpio_bd_out;
  logic                       gpint;
  logic                       ad9528_reset_b;
  logic                       sysref_req;
  logic                       tx1_en;
  logic                       tx2_en;
  logic                       rx1_en;
  logic                       rx2_en;
  logic                       test_pin;
  logic                       ad9371_reset_b;
  logic                       fifo_bypass;
  logic                       csn_ad9528;
  logic                       csn_ad9371;
  logic                       spi_clk;
  logic                       spi_mosi;
  logic                       spi_miso;
  logic                       cs_any_n;

  op_t                        ops[$];
  int                         n_checks;
  int                         n_errors;
  int                         cycles;

  // spi slave model state
  logic [23:0]                slv_resp;
  logic [23:0]                slv_tx;
  logic [23:0]                slv_rx;
  int                         slv_bits;
  int                         slv_frames;
  int                         cs0_falls;
  int                         cs1_falls;

  tb_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  board_top u_dut (
    .sys_clk_i           (clk),
    .arst_n_i            (arst_n),
    .host_wr_i           (host_wr),
    .host_rd_i           (host_rd),
    .host_addr_i         (host_addr),
    .host_wdata_i        (host_wdata),
    .host_rdata_o        (host_rdata),
    .host_rvalid_o       (host_rvalid),
    .gpio_bd_i           (gpio_bd_in),
    .gpio_bd_o           (gpio_bd_out),
    .ad9528_reset_b_o    (ad9528_reset_b),
    .ad9528_sysref_req_o (sysref_req),
    .ad9371_tx1_enable_o (tx1_en),
    .ad9371_tx2_enable_o (tx2_en),
    .ad9371_rx1_enable_o (rx1_en),
    .ad9371_rx2_enable_o (rx2_en),
    .ad9371_test_o       (test_pin),
    .ad9371_reset_b_o    (ad9371_reset_b),
    .ad9371_gpint_i      (gpint),
    .tx_fifo_bypass_o    (fifo_bypass),
    .spi_csn_ad9528_o    (csn_ad9528),
    .spi_csn_ad9371_o    (csn_ad9371),
    .spi_clk_o           (spi_clk),
    .spi_mosi_o          (spi_mosi),
    .spi_miso_i          (spi_miso)
  );

  // ********************************************************************
  // spi slave model, mode 0, msb first
  // ********************************************************************

  assign cs_any_n = csn_ad9528 & csn_ad9371;

  initial begin
    spi_miso = 1'b0;
    forever begin
      @(negedge cs_any_n);
      slv_tx   = slv_resp;
      slv_bits = 0;
      spi_miso = slv_tx[23];
      while (!cs_any_n) begin
        @(spi_clk or cs_any_n);
        if (!cs_any_n && spi_clk) begin
          slv_rx   = {slv_rx[22:0], spi_mosi};
          slv_bits = slv_bits + 1;
        end else if (!cs_any_n) begin
          slv_tx   = {slv_tx[22:0], 1'b0};
          spi_miso = slv_tx[23];
        end
      end
      slv_frames = slv_frames + 1;
    end
  end

  always @(negedge csn_ad9528) cs0_falls = cs0_falls + 1;
  always @(negedge csn_ad9371) cs1_falls = cs1_falls + 1;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (ops.size() > 0 && cycles >= ops.size() * CYCLES_PER_OP) begin
      $display("run stopped after %0d cycles, the test table did not finish", cycles);
      $display("sim failed");
      $finish;
    end
  end

  // ********************************************************************
  // helpers
  // ********************************************************************

  task automatic flag_error(input string msg);
    n_errors = n_errors + 1;
    $display("error at %0d ns: %s", $time, msg);
  endtask

  // named pins in bit map order, chip selects and clock on top
  function automatic logic [27:0] pins_now();
    return {csn_ad9528, csn_ad9371, spi_clk, fifo_bypass, ad9528_reset_b, sysref_req,
            tx1_en, tx2_en, rx1_en, rx2_en, test_pin, ad9371_reset_b, gpio_bd_out};
  endfunction

  function automatic logic [27:0] pin_expect(input logic [63:0] v);
    return {2'b11, 1'b0, v[`GPIO_BIT_FIFO_BYPASS], v[`GPIO_BIT_AD9528_RESET],
            v[`GPIO_BIT_SYSREF_REQ], v[`GPIO_BIT_TX1_ENABLE], v[`GPIO_BIT_TX2_ENABLE],
            v[`GPIO_BIT_RX1_ENABLE], v[`GPIO_BIT_RX2_ENABLE], v[`GPIO_BIT_TEST],
            v[`GPIO_BIT_AD9371_RESET], v[`GPIO_LED_MSB:`GPIO_LED_LSB]};
  endfunction

  task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
    host_wr    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(negedge clk);
    host_wr = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [31:0] data);
    host_rd   = 1'b1;
    host_addr = addr;
    @(negedge clk);
    host_rd  = 1'b0;
    data     = host_rdata;
    n_checks = n_checks + 1;
    if (host_rvalid !== 1'b1) begin
      flag_error($sformatf("no read valid one cycle after read of address %0d", addr));
    end
    @(negedge clk);
    n_checks = n_checks + 1;
    if (host_rvalid !== 1'b0) begin
      flag_error($sformatf("read valid of address %0d longer than one cycle", addr));
    end
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    bus_read(addr, got);
    n_checks = n_checks + 1;
    if (got !== exp) begin
      flag_error($sformatf("address %0d read %h, expected %h", addr, got, exp));
    end
  endtask

  task automatic spi_transfer(input logic [2:0] chip, input logic [23:0] frame,
                              input logic [23:0] resp, input logic retry_busy);
    logic [31:0] ctrl;
    logic [31:0] status;
    int          frames_before;
    int          cs0_before;
    int          cs1_before;
    slv_resp      = resp;
    frames_before = slv_frames;
    cs0_before    = cs0_falls;
    cs1_before    = cs1_falls;
    ctrl          = 32'd0;
    ctrl[`SPI_CTRL_START_BIT] = 1'b1;
    ctrl[2:0]     = chip;
    bus_write(`REG_SPI_TXDATA, {8'h00, frame});
    bus_write(`REG_SPI_CTRL, ctrl);
    // accepted start clears done and shows busy at once
    bus_read(`REG_SPI_STATUS, status);
    n_checks = n_checks + 1;
    if (status[1:0] !== 2'b01) begin
      flag_error($sformatf("status %b after start, expected busy only", status[1:0]));
    end
    if (retry_busy) begin
      repeat (6) @(negedge clk);
      ctrl[2:0] = chip ^ 3'd1;
      bus_write(`REG_SPI_TXDATA, {8'h00, ~frame});
      bus_write(`REG_SPI_CTRL, ctrl);
    end
    status = 32'h1;
    while (status[0] || !status[1]) begin
      bus_read(`REG_SPI_STATUS, status);
    end
    // room for a second frame that must not appear
    repeat (2 * `SPI_CLK_DIV + 4) @(negedge clk);
    n_checks = n_checks + 4;
    if (slv_frames - frames_before != 1) begin
      flag_error($sformatf("%0d spi frames seen, expected 1", slv_frames - frames_before));
    end
    if (slv_bits != `SPI_FRAME_BITS) begin
      flag_error($sformatf("slave counted %0d clock edges, expected 24", slv_bits));
    end
    if (slv_rx !== frame) begin
      flag_error($sformatf("slave captured %h, expected %h", slv_rx, frame));
    end
    if (cs0_falls - cs0_before != int'(chip == 3'd0) ||
        cs1_falls - cs1_before != int'(chip == 3'd1)) begin
      flag_error($sformatf("wrong chip select activity for chip %0d", chip));
    end
    read_check(`REG_SPI_RXDATA, {8'h00, resp});
  endtask

  task automatic add_op(input op_kind_t kind, input logic [3:0] addr,
                        input logic [63:0] data, input logic [63:0] expected);
    op_t op;
    op.kind     = kind;
    op.addr     = addr;
    op.data     = data;
    op.expected = expected;
    ops.push_back(op);
  endtask

  // ********************************************************************
  // stimulus table
  // ********************************************************************

  task automatic build_table();
    logic [63:0] out_model;
    logic [63:0] in_model;
    logic [31:0] rnd;
    out_model = 64'd0;
    add_op(K_PIN, 4'd0, 64'd0, {36'd0, pin_expect(out_model)});
    for (int i = 0; i < 2; i++) begin
      out_model[63:32] = $urandom;
      out_model[31:0]  = $urandom;
      add_op(K_WR, `REG_GPIO_OUT_HI, {32'd0, out_model[63:32]}, 64'd0);
      add_op(K_WR, `REG_GPIO_OUT_LO, {32'd0, out_model[31:0]}, 64'd0);
      add_op(K_PIN, 4'd0, 64'd0, {36'd0, pin_expect(out_model)});
      rnd      = $urandom;
      in_model = out_model;
      in_model[`GPIO_BD_IN_MSB:`GPIO_BD_IN_LSB] = rnd[10:0];
      in_model[`GPIO_BIT_GPINT] = rnd[11];
      add_op(K_INP, 4'd0, {52'd0, rnd[11:0]}, 64'd0);
      add_op(K_RD, `REG_GPIO_IN_LO, 64'd0, {32'd0, in_model[31:0]});
      add_op(K_RD, `REG_GPIO_IN_HI, 64'd0, {32'd0, in_model[63:32]});
      add_op(K_RD, `REG_GPIO_OUT_LO, 64'd0, {32'd0, out_model[31:0]});
    end
    add_op(K_RD, 4'd8, 64'd0, 64'd0);
    add_op(K_RD, 4'd15, 64'd0, 64'd0);
    // spi frames in data, slave responses in expected
    add_op(K_SPI, 4'd0, {40'd0, 24'($urandom)}, {40'd0, 24'($urandom)});
    add_op(K_SPI, 4'd1, {40'd0, 24'($urandom)}, {40'd0, 24'($urandom)});
    add_op(K_SPI_BUSY, 4'd0, {40'd0, 24'($urandom)}, {40'd0, 24'($urandom)});
    add_op(K_PIN, 4'd0, 64'd0, {36'd0, pin_expect(out_model)});
  endtask

  task automatic run_op(input op_t op);
    case (op.kind)
      K_WR:  bus_write(op.addr, op.data[31:0]);
      K_RD:  read_check(op.addr, op.expected[31:0]);
      K_PIN: begin
        n_checks = n_checks + 1;
        if (pins_now() !== op.expected[27:0]) begin
          flag_error($sformatf("pins %h, expected %h", pins_now(), op.expected[27:0]));
        end
      end
      K_INP: begin
        gpio_bd_in = op.data[10:0];
        gpint      = op.data[11];
        repeat (2) @(negedge clk);
      end
      K_SPI:      spi_transfer(op.addr[2:0], op.data[23:0], op.expected[23:0], 1'b0);
      K_SPI_BUSY: spi_transfer(op.addr[2:0], op.data[23:0], op.expected[23:0], 1'b1);
      default: flag_error("unknown table entry kind");
    endcase
  endtask

  initial begin
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = 4'd0;
    host_wdata = 32'd0;
    gpio_bd_in = 11'd0;
    gpint      = 1'b0;
    n_checks   = 0;
    n_errors   = 0;
    void'($urandom(3292));
    build_table();
    wait (arst_n === 1'b1);
    @(negedge clk);
    foreach (ops[i]) begin
      run_op(ops[i]);
    end
    $display("checks: %0d  errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/board_ctrl_pkg.sv
rtl/ctrl_regs.sv
rtl/spi_master.sv
rtl/board_top.sv
bench/tb_clkgen.sv
bench/tb_board_top.sv

// ==== Makefile ====
TOP := tb_board_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f rtl/*.sv rtl/*.svh bench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps +incdir+rtl \
		--top-module board_top rtl/board_ctrl_pkg.sv rtl/ctrl_regs.sv \
		rtl/spi_master.sv rtl/board_top.sv

clean:
	rm -rf obj_dir sim.log
